//--- cmd_sequencer.sv
`timescale 1ns/100ps

module cmd_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  matrix_pkg::mode_t sw,
    input  logic              btn_c,
    input  matrix_pkg::word_t number_out,
    input  logic              number_valid,
    input  matrix_pkg::word_t rd_data,
    input  logic              fifo_full,
    output logic              busy,
    output logic              wr_en,
    output matrix_pkg::slot_t wr_slot,
    output matrix_pkg::dim_t  wr_row,
    output matrix_pkg::dim_t  wr_col,
    output matrix_pkg::word_t wr_data,
    output logic              rd_en,
    output matrix_pkg::slot_t rd_slot,
    output matrix_pkg::dim_t  rd_row,
    output matrix_pkg::dim_t  rd_col,
    output logic              push,
    output matrix_pkg::word_t push_data
);
    import matrix_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PARAM,
        ST_IN_DATA,
        ST_DISP_READ,
        ST_DISP_PUSH
    } state_t;

    state_t     state;
    logic       disp_mode;
    logic [1:0] param_cnt;
    slot_t      slot;
    dim_t       dim_m;
    dim_t       dim_n;

    // Row-major walker
    dim_t       row;
    dim_t       col;
    logic [5:0] elem_cnt;
    logic [5:0] elem_total;

    logic mode_ok;
    logic dim_ok;
    logic dims_done;
    logic walk_step;
    logic col_last;
    logic elem_last;

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    // Only input and display codes start a command
    assign mode_ok   = (sw == MODE_INPUT) || (sw == MODE_DISPLAY);
    // Zero rows or columns is refused, the number is dropped
    assign dim_ok    = (number_out[2:0] != 3'd0);
    assign dims_done = (state == ST_PARAM) && number_valid && (param_cnt == 2'd2) && dim_ok;
    assign walk_step = ((state == ST_IN_DATA) && number_valid) || (state == ST_DISP_PUSH);
    assign col_last  = (col == dim_n - 3'd1);
    assign elem_last = (elem_cnt == elem_total - 6'd1);

    // ------------------------------------------------------------------
    // Command FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            disp_mode  <= 1'b0;
            param_cnt  <= 2'd0;
            slot       <= '0;
            dim_m      <= '0;
            dim_n      <= '0;
            elem_total <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    param_cnt <= 2'd0;
                    if (btn_c && mode_ok) begin
                        disp_mode <= (sw == MODE_DISPLAY);
                        state     <= ST_PARAM;
                    end
                end
                ST_PARAM: begin
                    // Slot, then M, then N
                    if (number_valid) begin
                        if (param_cnt == 2'd0) begin
                            slot      <= number_out[1:0];
                            param_cnt <= 2'd1;
                        end else if (param_cnt == 2'd1 && dim_ok) begin
                            dim_m     <= number_out[2:0];
                            param_cnt <= 2'd2;
                        end else if (dims_done) begin
                            dim_n      <= number_out[2:0];
                            elem_total <= 6'(dim_m) * 6'(number_out[2:0]);
                            state      <= disp_mode ? ST_DISP_READ : ST_IN_DATA;
                        end
                    end
                end
                ST_IN_DATA: begin
                    if (number_valid && elem_last) begin
                        state <= ST_IDLE;
                    end
                end
                // Hold the address until the FIFO has room
                ST_DISP_READ: begin
                    if (!fifo_full) begin
                        state <= ST_DISP_PUSH;
                    end
                end
                ST_DISP_PUSH: begin
                    state <= elem_last ? ST_IDLE : ST_DISP_READ;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Row/column walker and element counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row      <= '0;
            col      <= '0;
            elem_cnt <= '0;
        end else if (dims_done) begin
            row      <= '0;
            col      <= '0;
            elem_cnt <= '0;
        end else if (walk_step) begin
            elem_cnt <= elem_cnt + 6'd1;
            // Wrap column into the next row
            if (col_last) begin
                col <= '0;
                row <= row + 3'd1;
            end else begin
                col <= col + 3'd1;
            end
        end
    end

    // Store write lands one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= (state == ST_IN_DATA) && number_valid;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IN_DATA) && number_valid) begin
            wr_slot <= slot;
            wr_row  <= row;
            wr_col  <= col;
            wr_data <= number_out;
        end
    end

    // Read now, push the returned word next cycle
    assign rd_en     = (state == ST_DISP_READ) && !fifo_full;
    assign rd_slot   = slot;
    assign rd_row    = row;
    assign rd_col    = col;
    assign push      = (state == ST_DISP_PUSH);
    assign push_data = rd_data;
    assign busy      = (state != ST_IDLE);

    // Walk only ever runs over a non-empty matrix, inside its bounds
    a_dims_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {ST_IN_DATA, ST_DISP_READ, ST_DISP_PUSH})
        |-> (dim_m != 3'd0 && dim_n != 3'd0 && elem_cnt < elem_total));

endmodule

//--- hex_printer.sv
`timescale 1ns/100ps

module hex_printer (
    input  logic              clk,
    input  logic              rst_n,
    input  matrix_pkg::word_t pop_data,
    input  logic              empty,
    input  logic              tx_ack,
    output logic              pop,
    output matrix_pkg::byte_t tx_data,
    output logic              tx_req
);
    import matrix_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK_LOW
    } state_t;

    // Space plus four nibbles, index 4 is the last digit
    localparam logic [2:0] LAST_IDX = 3'd4;

    state_t     state;
    word_t      word_q;
    logic [2:0] char_idx;
    logic       advance;

    // 0-9 then A-F, 'A' sits at 8'h37 + 10
    function automatic byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // Character at a given position of the printed word
    function automatic byte_t char_at(input word_t w, input logic [2:0] idx);
        case (idx)
            3'd1:    return hex_char(w[15:12]);
            3'd2:    return hex_char(w[11:8]);
            3'd3:    return hex_char(w[7:4]);
            3'd4:    return hex_char(w[3:0]);
            default: return 8'h20;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Four-phase handshake
    // ------------------------------------------------------------------
    assign pop     = (state == ST_IDLE) && !empty;
    assign advance = (state == ST_ACK_LOW) && !tx_ack && (char_idx != LAST_IDX);
    assign tx_req  = (state == ST_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            char_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        char_idx <= '0;
                        state    <= ST_REQ;
                    end
                end
                // Hold request until the sink takes it
                ST_REQ: begin
                    if (tx_ack) begin
                        state <= ST_ACK_LOW;
                    end
                end
                // Byte done once ack falls
                ST_ACK_LOW: begin
                    if (!tx_ack) begin
                        if (char_idx == LAST_IDX) begin
                            state <= ST_IDLE;
                        end else begin
                            char_idx <= char_idx + 3'd1;
                            state    <= ST_REQ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Word and character registers
    always_ff @(posedge clk) begin
        if (pop) begin
            word_q  <= pop_data;
            tx_data <= 8'h20;
        end else if (advance) begin
            tx_data <= char_at(word_q, char_idx + 3'd1);
        end
    end

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_req && !tx_ack) |=> (tx_req && $stable(tx_data)));

endmodule

//--- matrix_console_top.sv
`timescale 1ns/100ps

module matrix_console_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  matrix_pkg::mode_t sw,
    input  logic              btn_c,
    input  matrix_pkg::word_t number_out,
    input  logic              number_valid,
    output logic              busy,
    output matrix_pkg::byte_t tx_data,
    output logic              tx_req,
    input  logic              tx_ack
);
    import matrix_pkg::*;

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------
    // Store write side
    logic  wr_en;
    slot_t wr_slot;
    dim_t  wr_row;
    dim_t  wr_col;
    word_t wr_data;

    // Store read side
    logic  rd_en;
    slot_t rd_slot;
    dim_t  rd_row;
    dim_t  rd_col;
    word_t rd_data;

    // FIFO
    logic  push;
    word_t push_data;
    logic  pop;
    word_t pop_data;
    logic  fifo_full;
    logic  fifo_empty;

    // Producer, collects parameters and walks the store
    cmd_sequencer seq_i (
        .clk, .rst_n, .sw, .btn_c, .number_out, .number_valid,
        .rd_data, .fifo_full, .busy,
        .wr_en, .wr_slot, .wr_row, .wr_col, .wr_data,
        .rd_en, .rd_slot, .rd_row, .rd_col,
        .push, .push_data
    );

    matrix_store store_i (
        .clk, .wr_en, .wr_slot, .wr_row, .wr_col, .wr_data,
        .rd_en, .rd_slot, .rd_row, .rd_col, .rd_data
    );

    // Buffer between read-back and the slow byte port
    word_fifo #(.DEPTH(FIFO_DEPTH)) fifo_i (
        .clk, .rst_n, .push, .push_data, .pop, .pop_data,
        .full(fifo_full), .empty(fifo_empty)
    );

    // Consumer
    hex_printer printer_i (
        .clk, .rst_n, .pop_data, .empty(fifo_empty), .tx_ack,
        .pop, .tx_data, .tx_req
    );

endmodule

//--- matrix_pkg.sv
package matrix_pkg;

    // ------------------------------------------------------------------
    // Data and index types
    // ------------------------------------------------------------------

    // One matrix element, also one FIFO entry
    typedef logic [15:0] word_t;

    // Slot index, four matrices in the store
    typedef logic [1:0] slot_t;

    // Row or column count or index, counts run 1..7
    typedef logic [2:0] dim_t;

    // One character on the byte port
    typedef logic [7:0] byte_t;

    // ------------------------------------------------------------------
    // Switch codes and store geometry
    // ------------------------------------------------------------------

    // Raw switch code from the board
    typedef logic [2:0] mode_t;

    localparam mode_t MODE_INPUT   = 3'd0;
    localparam mode_t MODE_DISPLAY = 3'd2;

    // Slots, and rows/columns reserved per slot
    localparam int SLOT_COUNT = 4;
    localparam int ROW_MAX    = 8;

endpackage

//--- matrix_store.sv
`timescale 1ns/100ps

module matrix_store (
    input  logic              clk,
    input  logic              wr_en,
    input  matrix_pkg::slot_t wr_slot,
    input  matrix_pkg::dim_t  wr_row,
    input  matrix_pkg::dim_t  wr_col,
    input  matrix_pkg::word_t wr_data,
    input  logic              rd_en,
    input  matrix_pkg::slot_t rd_slot,
    input  matrix_pkg::dim_t  rd_row,
    input  matrix_pkg::dim_t  rd_col,
    output matrix_pkg::word_t rd_data
);
    import matrix_pkg::*;

    // Every slot gets a full ROW_MAX x ROW_MAX page
    localparam int DEPTH  = SLOT_COUNT * ROW_MAX * ROW_MAX;
    localparam int ADDR_W = $clog2(DEPTH);

    word_t mem [DEPTH];

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // Flat address, slot on top, then row, then column
    assign wr_addr = {wr_slot, wr_row, wr_col};
    assign rd_addr = {rd_slot, rd_row, rd_col};

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------------
    // Read port, one cycle latency
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        // Output holds its last value between reads
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the testbench and RTL with Verilator, run it, then scan the log

rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_matrix_console -f tb.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Build error, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q '^>>> FAIL' sim.log && exit 1
grep -q '^>>> PASS' sim.log || { echo "No pass line found in sim.log"; exit 1; }
exit 0

//--- tb.f
matrix_pkg.sv
matrix_store.sv
cmd_sequencer.sv
word_fifo.sv
hex_printer.sv
matrix_console_top.sv
tb_matrix_console.sv

//--- tb_matrix_console.sv
`timescale 1ns/100ps

module tb_matrix_console;
    import matrix_pkg::*;

    localparam int N_TESTS = 6;

    logic  clk;
    logic  rst_n;
    mode_t sw;
    logic  btn_c;
    word_t number_out;
    logic  number_valid;
    logic  busy;
    byte_t tx_data;
    logic  tx_req;
    logic  tx_ack;

    // ------------------------------------------------------------------
    // Test table as one array per column
    // ------------------------------------------------------------------
    string t_name  [N_TESTS] = '{"fill_s1_3x4", "fill_s2_7x7", "show_s1_slow",
                                 "refill_s2_2x5", "show_s1_again", "fill_s0_1x1"};
    slot_t t_slot  [N_TESTS] = '{2'd1, 2'd2, 2'd1, 2'd2, 2'd1, 2'd0};
    dim_t  t_m     [N_TESTS] = '{3'd3, 3'd7, 3'd3, 3'd2, 3'd3, 3'd1};
    dim_t  t_n     [N_TESTS] = '{3'd4, 3'd7, 3'd4, 3'd5, 3'd4, 3'd1};
    logic  t_write [N_TESTS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    logic  t_slow  [N_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

    // Switch codes with no function
    mode_t bad_codes [6] = '{3'd1, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7};

    // Reference copy of the store
    word_t       model [SLOT_COUNT][ROW_MAX][ROW_MAX];
    byte_t       rx_q [$];
    logic [31:0] lfsr = 32'h9b687512;
    logic        slow_ack = 1'b0;
    logic        req_q = 1'b0;
    word_t       ack_bits;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    string       hex_digits = "0123456789ABCDEF";

    matrix_console_top #(.FIFO_DEPTH(4)) dut_i (
        .clk, .rst_n, .sw, .btn_c, .number_out, .number_valid,
        .busy, .tx_data, .tx_req, .tx_ack
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s: expected 8'h%02h, got 8'h%02h", name, exp, act));
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s: busy expected %b, got %b", name, exp, act));
        end
    endtask

    // Land just after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic press_button(input mode_t code);
        sw    = code;
        btn_c = 1'b1;
        next_cycle();
        btn_c = 1'b0;
    endtask

    task automatic drive_number(input word_t v);
        number_out   = v;
        number_valid = 1'b1;
        next_cycle();
        number_valid = 1'b0;
    endtask

    // Input command with busy held until the last element
    task automatic run_input(input string name, input slot_t s, input dim_t m, input dim_t n);
        word_t v;
        press_button(MODE_INPUT);
        check_busy(name, 1'b1, busy);
        drive_number(word_t'(s));
        drive_number(word_t'(m));
        drive_number(word_t'(n));
        for (int r = 0; r < int'(m); r++) begin
            for (int c = 0; c < int'(n); c++) begin
                rand_bits(16, v);
                model[s][r][c] = v;
                check_busy(name, 1'b1, busy);
                drive_number(v);
            end
        end
        check_busy(name, 1'b0, busy);
    endtask

    // Display command expecting a space plus four digits per element
    task automatic run_display(input string name, input slot_t s, input dim_t m, input dim_t n);
        byte_t exp_q [$];
        word_t w;
        rx_q.delete();
        press_button(MODE_DISPLAY);
        check_busy(name, 1'b1, busy);
        drive_number(word_t'(s));
        drive_number(word_t'(m));
        drive_number(word_t'(n));
        for (int r = 0; r < int'(m); r++) begin
            for (int c = 0; c < int'(n); c++) begin
                w = model[s][r][c];
                exp_q.push_back(8'h20);
                for (int k = 3; k >= 0; k--) begin
                    exp_q.push_back(byte_t'(hex_digits[int'(w[4*k +: 4])]));
                end
            end
        end
        while (busy) next_cycle();
        while (rx_q.size() < exp_q.size()) next_cycle();
        // Room for a stray extra byte to show up
        repeat (20) next_cycle();
        if (rx_q.size() != exp_q.size()) begin
            fail_now($sformatf("%s: received %0d bytes where %0d were due",
                               name, rx_q.size(), exp_q.size()));
        end
        foreach (exp_q[i]) begin
            check_byte(name, exp_q[i], rx_q[i]);
        end
    endtask

    // ------------------------------------------------------------------
    // Byte sink, monitor and cycle limit
    // ------------------------------------------------------------------
    always begin
        @(posedge clk);
        if (tx_req === 1'b1 && tx_ack === 1'b0) begin
            ack_bits = '0;
            if (slow_ack) begin
                rand_bits(2, ack_bits);
            end
            repeat (int'(ack_bits[1:0])) @(posedge clk);
            #0.5 tx_ack = 1'b1;
            // Hold ack until the request drops
            do begin
                @(posedge clk);
            end while (tx_req);
            #0.5 tx_ack = 1'b0;
        end
    end

    // One byte per rising request
    always @(posedge clk) begin
        if (tx_req === 1'b1 && !req_q) begin
            rx_q.push_back(tx_data);
        end
        req_q = (tx_req === 1'b1);
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            fail_now($sformatf("Timeout, the run was still going after %0d cycles", cycle_cnt));
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int    total;
        word_t v;
        clk          = 1'b0;
        rst_n        = 1'b1;
        sw           = MODE_INPUT;
        btn_c        = 1'b0;
        number_out   = '0;
        number_valid = 1'b0;
        tx_ack       = 1'b0;
        total        = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            total += int'(t_m[i]) * int'(t_n[i]);
        end
        cycle_limit = total * 5 * 12 + 2000;
        #1 rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #0.5 rst_n = 1'b1;

        // Quiet after reset
        repeat (8) begin
            check_busy("reset_idle", 1'b0, busy);
            if (tx_req !== 1'b0) fail_now("tx_req went high after reset with no command");
            next_cycle();
        end

        for (int i = 0; i < N_TESTS; i++) begin
            if (t_write[i]) begin
                run_input(t_name[i], t_slot[i], t_m[i], t_n[i]);
            end
            slow_ack = t_slow[i];
            run_display(t_name[i], t_slot[i], t_m[i], t_n[i]);
        end

        // Unused codes start nothing
        rx_q.delete();
        foreach (bad_codes[i]) begin
            press_button(bad_codes[i]);
            repeat (3) begin
                check_busy("bad_code", 1'b0, busy);
                next_cycle();
            end
        end
        if (rx_q.size() != 0) fail_now("Bytes were sent after an unused switch code");

        // Numbers while idle must not reach the store
        repeat (5) begin
            rand_bits(16, v);
            drive_number(v);
            check_busy("idle_numbers", 1'b0, busy);
        end
        // Last written matrix still sits at the held write address
        slow_ack = 1'b1;
        run_display("after_stray", t_slot[N_TESTS-1], t_m[N_TESTS-1], t_n[N_TESTS-1]);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- word_fifo.sv
`timescale 1ns/100ps

module word_fifo #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  matrix_pkg::word_t push_data,
    input  logic              pop,
    output matrix_pkg::word_t pop_data,
    output logic              full,
    output logic              empty
);
    import matrix_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointer step, wraps for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Count unchanged on simultaneous push and pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry straight out
    assign pop_data = mem[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    // Sequencer and printer must respect the flags
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule
